//--- rtl/mem_ui_pkg.sv
package mem_ui_pkg;

	// ------------------------------------------------------------
	// DDR user-interface data path
	// ------------------------------------------------------------

	// One app_wdf_data / app_rd_data beat
	localparam int STRIP_BITS = 128;
	// One mask bit per byte, a set bit keeps the byte unwritten
	localparam int MASK_BITS = STRIP_BITS / 8;

	typedef enum logic [2:0] {
		CMD_WRITE = 3'b000,
		CMD_READ  = 3'b001
	} app_cmd_t;

	// A strip seen either as narrow words or as CPU words
	typedef union packed {
		logic [STRIP_BITS/32-1:0][31:0] lane32;
		logic [STRIP_BITS/64-1:0][63:0] lane64;
	} strip_t;

endpackage

//--- rtl/client_pkg.sv
package client_pkg;

	// ------------------------------------------------------------
	// Client ports
	// ------------------------------------------------------------

	// Enum value doubles as the bit index of one-hot channel vectors
	typedef enum logic [1:0] {
		CH_DISPLAY = 2'd0,
		CH_NARROW  = 2'd1,
		CH_CPU     = 2'd2,
		CH_NONE    = 2'd3
	} chan_t;

	localparam int NARROW_BITS = 32;
	localparam int CPU_BITS = 64;

	// Strips fetched per read miss
	localparam int STRIPS_DISPLAY = 4;
	localparam int STRIPS_CPU = 2;

endpackage

//--- rtl/request_select.sv
`timescale 1ns/1ps

module request_select #(
	parameter int ADDR_WIDTH = 29
) (
	input  logic disp_cyc,
	input  logic disp_stb,
	input  logic disp_we,
	input  logic [mem_ui_pkg::MASK_BITS-1:0] disp_sel,
	input  logic [31:0] disp_adr,
	input  logic [mem_ui_pkg::STRIP_BITS-1:0] disp_dat_i,
	input  logic disp_hit,
	input  logic nar_cyc,
	input  logic nar_stb,
	input  logic nar_we,
	input  logic [client_pkg::NARROW_BITS/8-1:0] nar_sel,
	input  logic [31:0] nar_adr,
	input  logic [client_pkg::NARROW_BITS-1:0] nar_dat_i,
	input  logic nar_hit,
	input  logic cpu_cyc,
	input  logic cpu_stb,
	input  logic cpu_we,
	input  logic [client_pkg::CPU_BITS/8-1:0] cpu_sel,
	input  logic [31:0] cpu_adr,
	input  logic [client_pkg::CPU_BITS-1:0] cpu_dat_i,
	input  logic cpu_hit,
	output logic req_valid,
	output client_pkg::chan_t req_ch,
	output logic req_we,
	output logic [ADDR_WIDTH-1:0] req_addr,
	output logic [mem_ui_pkg::MASK_BITS-1:0] req_mask,
	output mem_ui_pkg::strip_t req_data,
	output logic [2:0] req_strips
);
	import mem_ui_pkg::*;
	import client_pkg::*;

	logic disp_cs;
	logic nar_cs;
	logic cpu_cs;
	chan_t sel_ch;

	assign disp_cs = disp_cyc & disp_stb;
	assign nar_cs = nar_cyc & nar_stb;
	assign cpu_cs = cpu_cyc & cpu_stb;

	// Display first, then writes, then the remaining read misses
	always_comb begin
		if (disp_cs && (disp_we || !disp_hit))
			sel_ch = CH_DISPLAY;
		else if (nar_cs && nar_we)
			sel_ch = CH_NARROW;
		else if (cpu_cs && cpu_we)
			sel_ch = CH_CPU;
		else if (nar_cs && !nar_hit)
			sel_ch = CH_NARROW;
		else if (cpu_cs && !cpu_hit)
			sel_ch = CH_CPU;
		else
			sel_ch = CH_NONE;
	end

	// ------------------------------------------------------------
	// Request formatting for the chosen port
	// ------------------------------------------------------------
	always_comb begin
		req_valid = (sel_ch != CH_NONE);
		req_ch = sel_ch;
		req_we = 1'b0;
		req_addr = '0;
		req_mask = '1;
		req_data = '0;
		req_strips = 3'd1;
		case (sel_ch)
		CH_DISPLAY: begin
			req_we = disp_we;
			// Reads fetch the whole 64-byte line
			if (disp_we)
				req_addr = {disp_adr[ADDR_WIDTH-1:4], 4'd0};
			else
				req_addr = {disp_adr[ADDR_WIDTH-1:6], 6'd0};
			req_mask = ~disp_sel;
			req_data = disp_dat_i;
			req_strips = disp_we ? 3'd1 : 3'(STRIPS_DISPLAY);
		end
		CH_NARROW: begin
			req_we = nar_we;
			req_addr = {nar_adr[ADDR_WIDTH-1:4], 4'd0};
			req_mask[nar_adr[3:2]*(NARROW_BITS/8) +: NARROW_BITS/8] = ~nar_sel;
			req_data.lane32 = {(STRIP_BITS/NARROW_BITS){nar_dat_i}};
		end
		CH_CPU: begin
			req_we = cpu_we;
			if (cpu_we)
				req_addr = {cpu_adr[ADDR_WIDTH-1:4], 4'd0};
			else
				req_addr = {cpu_adr[ADDR_WIDTH-1:5], 5'd0};
			req_mask[cpu_adr[3]*(CPU_BITS/8) +: CPU_BITS/8] = ~cpu_sel;
			req_data.lane64 = {(STRIP_BITS/CPU_BITS){cpu_dat_i}};
			req_strips = cpu_we ? 3'd1 : 3'(STRIPS_CPU);
		end
		default: ;
		endcase
	end

endmodule

//--- rtl/app_sequencer.sv
`timescale 1ns/1ps

module app_sequencer #(
	parameter int ADDR_WIDTH = 29,
	parameter int RD_TIMEOUT = 120
) (
	input  logic mem_ui_clk,
	input  logic mem_ui_rst,
	input  logic req_valid,
	input  client_pkg::chan_t req_ch,
	input  logic req_we,
	input  logic [ADDR_WIDTH-1:0] req_addr,
	input  logic [mem_ui_pkg::MASK_BITS-1:0] req_mask,
	input  mem_ui_pkg::strip_t req_data,
	input  logic [2:0] req_strips,
	input  logic app_rdy,
	input  logic app_wdf_rdy,
	input  logic app_rd_data_valid,
	input  logic init_calib_complete,
	output logic [ADDR_WIDTH-1:0] app_addr,
	output mem_ui_pkg::app_cmd_t app_cmd,
	output logic app_en,
	output logic [mem_ui_pkg::STRIP_BITS-1:0] app_wdf_data,
	output logic [mem_ui_pkg::MASK_BITS-1:0] app_wdf_mask,
	output logic app_wdf_wren,
	output logic app_wdf_end,
	output logic [2:0] fill_en,
	output logic [1:0] fill_idx,
	output logic fill_last,
	output logic snoop_en,
	output logic [31:0] snoop_adr,
	output logic [2:0] wr_done
);
	import mem_ui_pkg::*;
	import client_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		PRESET,
		SEND_DATA,
		SET_CMD_WR,
		SET_CMD_RD,
		WAIT_RD
	} state_t;

	localparam int TO_W = $clog2(RD_TIMEOUT + 1);

	state_t state;
	chan_t cur_ch;
	logic cur_we;
	logic [1:0] last_idx;
	// Read commands accepted and strips returned
	logic [1:0] iss_cnt;
	logic [1:0] rd_cnt;
	logic [TO_W-1:0] to_cnt;
	logic rd_beat;
	logic timed_out;

	assign rd_beat = app_rd_data_valid && (state == SET_CMD_RD || state == WAIT_RD);
	assign timed_out = (to_cnt == TO_W'(RD_TIMEOUT - 1));

	// ------------------------------------------------------------
	// Command FSM
	// ------------------------------------------------------------
	always_ff @(posedge mem_ui_clk) begin
		if (mem_ui_rst) begin
			state <= IDLE;
			snoop_en <= 1'b0;
			iss_cnt <= '0;
			rd_cnt <= '0;
			to_cnt <= '0;
		end else begin
			snoop_en <= 1'b0;
			case (state)
			IDLE:
				if (init_calib_complete && req_valid) begin
					// Caches drop any line holding the write address
					snoop_en <= req_we;
					iss_cnt <= '0;
					rd_cnt <= '0;
					state <= PRESET;
				end
			PRESET: begin
				to_cnt <= '0;
				state <= cur_we ? SEND_DATA : SET_CMD_RD;
			end
			SEND_DATA:
				if (app_wdf_rdy)
					state <= SET_CMD_WR;
			SET_CMD_WR:
				if (app_rdy)
					state <= IDLE;
			SET_CMD_RD, WAIT_RD: begin
				to_cnt <= to_cnt + 1'b1;
				if (state == SET_CMD_RD && app_rdy) begin
					iss_cnt <= iss_cnt + 1'b1;
					if (iss_cnt == last_idx)
						state <= WAIT_RD;
				end
				if (rd_beat)
					rd_cnt <= rd_cnt + 1'b1;
				// Give up on a stuck read, the client retries on the next miss
				if ((rd_beat && fill_last) || timed_out)
					state <= IDLE;
			end
			default:
				state <= IDLE;
			endcase
		end
	end

	// Request capture and burst address stepping
	always_ff @(posedge mem_ui_clk) begin
		if (state == IDLE && init_calib_complete) begin
			cur_ch <= req_ch;
			cur_we <= req_we;
			last_idx <= 2'(req_strips - 3'd1);
			app_addr <= req_addr;
			app_wdf_data <= req_data;
			app_wdf_mask <= req_mask;
			snoop_adr <= 32'(req_addr);
		end else if (state == SET_CMD_RD && app_rdy) begin
			app_addr <= app_addr + ADDR_WIDTH'(STRIP_BITS / 8);
		end
	end

	// ------------------------------------------------------------
	// app_* drive and per-channel strobes
	// ------------------------------------------------------------
	assign app_en = (state == SET_CMD_WR) || (state == SET_CMD_RD);
	assign app_cmd = (state == SET_CMD_RD) ? CMD_READ : CMD_WRITE;
	assign app_wdf_wren = (state == SEND_DATA);
	assign app_wdf_end = (state == SEND_DATA);

	assign fill_en = rd_beat ? (3'b001 << cur_ch) : 3'b000;
	assign fill_idx = rd_cnt;
	assign fill_last = (rd_cnt == last_idx);
	assign wr_done = (state == SET_CMD_WR && app_rdy) ? (3'b001 << cur_ch) : 3'b000;

endmodule

//--- rtl/line_cache.sv
`timescale 1ns/1ps

module line_cache #(
	parameter int STRIPS = 1,
	parameter int LANE_WIDTH = 128
) (
	input  logic mem_ui_clk,
	input  logic mem_ui_rst,
	input  logic [31:0] adr,
	output logic hit,
	output logic [LANE_WIDTH-1:0] dat_o,
	input  logic fill_en,
	input  logic [1:0] fill_idx,
	input  logic fill_last,
	input  mem_ui_pkg::strip_t fill_data,
	input  logic snoop_en,
	input  logic [31:0] snoop_adr
);
	import mem_ui_pkg::*;

	// Line is STRIPS strips of 16 bytes
	localparam int LINE_LSB = $clog2(STRIPS * STRIP_BITS / 8);
	localparam int IDX_W = (STRIPS > 1) ? $clog2(STRIPS) : 1;

	strip_t strips [STRIPS];
	logic [31:LINE_LSB] tag;
	logic tag_valid;
	logic [IDX_W-1:0] wr_idx;
	logic [IDX_W-1:0] rd_idx;
	strip_t cur;

	assign hit = tag_valid && (tag == adr[31:LINE_LSB]);
	assign wr_idx = (STRIPS > 1) ? fill_idx[IDX_W-1:0] : '0;
	assign rd_idx = (STRIPS > 1) ? adr[4 +: IDX_W] : '0;
	assign cur = strips[rd_idx];

	always_ff @(posedge mem_ui_clk) begin
		if (mem_ui_rst)
			tag_valid <= 1'b0;
		else if (fill_en && fill_last)
			tag_valid <= 1'b1;
		else if (snoop_en && snoop_adr[31:LINE_LSB] == tag)
			tag_valid <= 1'b0;
	end

	// Client holds adr through the miss, so it names the line being filled
	always_ff @(posedge mem_ui_clk) begin
		if (fill_en) begin
			strips[wr_idx] <= fill_data;
			if (fill_last)
				tag <= adr[31:LINE_LSB];
		end
	end

	// Lane pick follows the port width
	always_ff @(posedge mem_ui_clk) begin
		case (LANE_WIDTH)
		32:      dat_o <= LANE_WIDTH'(cur.lane32[adr[3:2]]);
		64:      dat_o <= LANE_WIDTH'(cur.lane64[adr[3]]);
		default: dat_o <= LANE_WIDTH'(cur);
		endcase
	end

endmodule

//--- rtl/ack_ctrl.sv
`timescale 1ns/1ps

module ack_ctrl (
	input  logic mem_ui_clk,
	input  logic mem_ui_rst,
	input  logic disp_cyc,
	input  logic disp_stb,
	input  logic disp_we,
	input  logic disp_hit,
	input  logic nar_cyc,
	input  logic nar_stb,
	input  logic nar_we,
	input  logic nar_hit,
	input  logic cpu_cyc,
	input  logic cpu_stb,
	input  logic cpu_we,
	input  logic cpu_hit,
	input  logic [2:0] wr_done,
	output logic disp_ack,
	output logic nar_ack,
	output logic cpu_ack
);
	// Bit order matches the channel encoding
	logic [2:0] cs;
	logic [2:0] rd_hit;
	logic [2:0] ack_r;

	assign cs = {cpu_cyc & cpu_stb, nar_cyc & nar_stb, disp_cyc & disp_stb};
	assign rd_hit = cs & ~{cpu_we, nar_we, disp_we} & {cpu_hit, nar_hit, disp_hit};

	// Held while selected, dropped once the port lets go
	always_ff @(posedge mem_ui_clk) begin
		if (mem_ui_rst)
			ack_r <= 3'b000;
		else
			ack_r <= (ack_r | rd_hit | wr_done) & cs;
	end

	assign {cpu_ack, nar_ack, disp_ack} = ack_r & cs;

endmodule

//--- rtl/mpmc_top.sv
`timescale 1ns/1ps

module mpmc_top #(
	parameter int ADDR_WIDTH = 29,
	parameter int RD_TIMEOUT = 120
) (
	input  logic mem_ui_clk,
	input  logic mem_ui_rst,
	// Display port
	input  logic disp_cyc,
	input  logic disp_stb,
	input  logic disp_we,
	input  logic [mem_ui_pkg::MASK_BITS-1:0] disp_sel,
	input  logic [31:0] disp_adr,
	input  logic [mem_ui_pkg::STRIP_BITS-1:0] disp_dat_i,
	output logic [mem_ui_pkg::STRIP_BITS-1:0] disp_dat_o,
	output logic disp_ack,
	// Narrow port
	input  logic nar_cyc,
	input  logic nar_stb,
	input  logic nar_we,
	input  logic [client_pkg::NARROW_BITS/8-1:0] nar_sel,
	input  logic [31:0] nar_adr,
	input  logic [client_pkg::NARROW_BITS-1:0] nar_dat_i,
	output logic [client_pkg::NARROW_BITS-1:0] nar_dat_o,
	output logic nar_ack,
	// CPU port
	input  logic cpu_cyc,
	input  logic cpu_stb,
	input  logic cpu_we,
	input  logic [client_pkg::CPU_BITS/8-1:0] cpu_sel,
	input  logic [31:0] cpu_adr,
	input  logic [client_pkg::CPU_BITS-1:0] cpu_dat_i,
	output logic [client_pkg::CPU_BITS-1:0] cpu_dat_o,
	output logic cpu_ack,
	// DDR user interface
	input  logic init_calib_complete,
	output logic [ADDR_WIDTH-1:0] app_addr,
	output logic [2:0] app_cmd,
	output logic app_en,
	output logic [mem_ui_pkg::STRIP_BITS-1:0] app_wdf_data,
	output logic [mem_ui_pkg::MASK_BITS-1:0] app_wdf_mask,
	output logic app_wdf_wren,
	output logic app_wdf_end,
	input  logic app_rdy,
	input  logic app_wdf_rdy,
	input  logic [mem_ui_pkg::STRIP_BITS-1:0] app_rd_data,
	input  logic app_rd_data_valid
);
	import mem_ui_pkg::*;
	import client_pkg::*;

	logic req_valid;
	chan_t req_ch;
	logic req_we;
	logic [ADDR_WIDTH-1:0] req_addr;
	logic [MASK_BITS-1:0] req_mask;
	strip_t req_data;
	logic [2:0] req_strips;
	logic [2:0] fill_en;
	logic [1:0] fill_idx;
	logic fill_last;
	logic snoop_en;
	logic [31:0] snoop_adr;
	logic [2:0] wr_done;
	logic disp_hit;
	logic nar_hit;
	logic cpu_hit;

	request_select #(.ADDR_WIDTH(ADDR_WIDTH)) u_select (
		.disp_cyc, .disp_stb, .disp_we, .disp_sel, .disp_adr, .disp_dat_i, .disp_hit,
		.nar_cyc, .nar_stb, .nar_we, .nar_sel, .nar_adr, .nar_dat_i, .nar_hit,
		.cpu_cyc, .cpu_stb, .cpu_we, .cpu_sel, .cpu_adr, .cpu_dat_i, .cpu_hit,
		.req_valid, .req_ch, .req_we, .req_addr, .req_mask, .req_data, .req_strips
	);

	app_sequencer #(.ADDR_WIDTH(ADDR_WIDTH), .RD_TIMEOUT(RD_TIMEOUT)) u_seq (
		.mem_ui_clk, .mem_ui_rst,
		.req_valid, .req_ch, .req_we, .req_addr, .req_mask, .req_data, .req_strips,
		.app_rdy, .app_wdf_rdy, .app_rd_data_valid, .init_calib_complete,
		.app_addr, .app_cmd, .app_en, .app_wdf_data, .app_wdf_mask,
		.app_wdf_wren, .app_wdf_end,
		.fill_en, .fill_idx, .fill_last, .snoop_en, .snoop_adr, .wr_done
	);

	ack_ctrl u_ack (
		.mem_ui_clk, .mem_ui_rst,
		.disp_cyc, .disp_stb, .disp_we, .disp_hit,
		.nar_cyc, .nar_stb, .nar_we, .nar_hit,
		.cpu_cyc, .cpu_stb, .cpu_we, .cpu_hit,
		.wr_done, .disp_ack, .nar_ack, .cpu_ack
	);

	// ------------------------------------------------------------
	// Per-port read caches
	// ------------------------------------------------------------
	line_cache #(.STRIPS(STRIPS_DISPLAY), .LANE_WIDTH(STRIP_BITS)) disp_cache (
		.mem_ui_clk, .mem_ui_rst, .adr(disp_adr), .hit(disp_hit), .dat_o(disp_dat_o),
		.fill_en(fill_en[CH_DISPLAY]), .fill_idx, .fill_last, .fill_data(app_rd_data),
		.snoop_en, .snoop_adr
	);

	line_cache #(.STRIPS(1), .LANE_WIDTH(NARROW_BITS)) nar_cache (
		.mem_ui_clk, .mem_ui_rst, .adr(nar_adr), .hit(nar_hit), .dat_o(nar_dat_o),
		.fill_en(fill_en[CH_NARROW]), .fill_idx, .fill_last, .fill_data(app_rd_data),
		.snoop_en, .snoop_adr
	);

	line_cache #(.STRIPS(STRIPS_CPU), .LANE_WIDTH(CPU_BITS)) cpu_cache (
		.mem_ui_clk, .mem_ui_rst, .adr(cpu_adr), .hit(cpu_hit), .dat_o(cpu_dat_o),
		.fill_en(fill_en[CH_CPU]), .fill_idx, .fill_last, .fill_data(app_rd_data),
		.snoop_en, .snoop_adr
	);

endmodule

//--- tests/mem_model.sv
`timescale 1ns/1ps

module mem_model #(
	parameter int ADDR_WIDTH = 29
) (
	input  logic mem_ui_clk,
	input  logic mem_ui_rst,
	input  logic [ADDR_WIDTH-1:0] app_addr,
	input  logic [2:0] app_cmd,
	input  logic app_en,
	input  logic [127:0] app_wdf_data,
	input  logic [15:0] app_wdf_mask,
	input  logic app_wdf_wren,
	input  logic app_wdf_end,
	output logic app_rdy,
	output logic app_wdf_rdy,
	output logic [127:0] app_rd_data,
	output logic app_rd_data_valid,
	output logic init_calib_complete,
	output int rd_cmds,
	output int wr_cmds
);
	// 4 KB of 32-bit words, strip index from address bits 11:4
	logic [31:0] mem [1024];
	// Addresses of accepted write commands, oldest first
	logic [ADDR_WIDTH-1:0] wr_log [16];
	logic [ADDR_WIDTH-1:0] rd_adr_q [$];
	int rd_due_q [$];
	logic [127:0] wdf_data;
	logic [15:0] wdf_mask;
	logic [31:0] rnd;
	int cycle;
	int calib_cnt;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [127:0] read_strip(input logic [ADDR_WIDTH-1:0] adr);
		logic [127:0] s;
		for (int k = 0; k < 4; k++)
			s[k*32 +: 32] = mem[{adr[11:4], 2'(k)}];
		return s;
	endfunction

	// A set mask bit keeps the stored byte
	task automatic write_strip(input logic [ADDR_WIDTH-1:0] adr, input logic [127:0] d,
			input logic [15:0] m);
		for (int j = 0; j < 16; j++)
			if (!m[j])
				mem[{adr[11:4], 2'(j / 4)}][(j % 4) * 8 +: 8] = d[j*8 +: 8];
	endtask

	// Every word starts as its own byte address with a marker in the upper half
	initial begin
		for (int i = 0; i < 1024; i++)
			mem[i] = {20'd0, 10'(i), 2'b00} ^ 32'h5a5a0000;
		app_rdy = 1'b0;
		app_wdf_rdy = 1'b0;
		app_rd_data = '0;
		app_rd_data_valid = 1'b0;
		init_calib_complete = 1'b0;
		rd_cmds = 0;
		wr_cmds = 0;
	end

	always @(posedge mem_ui_clk) begin
		if (mem_ui_rst) begin
			rnd <= 32'h0f2c06ed;
			cycle <= 0;
			calib_cnt <= 0;
			app_rdy <= 1'b0;
			app_wdf_rdy <= 1'b0;
			app_rd_data_valid <= 1'b0;
			init_calib_complete <= 1'b0;
			rd_cmds <= 0;
			wr_cmds <= 0;
			rd_adr_q.delete();
			rd_due_q.delete();
		end else begin
			rnd <= xorshift(rnd);
			cycle <= cycle + 1;
			// Roughly one cycle in four stalls
			app_rdy <= rnd[0] | rnd[1];
			app_wdf_rdy <= rnd[2] | rnd[3];
			if (calib_cnt < 8)
				calib_cnt <= calib_cnt + 1;
			init_calib_complete <= (calib_cnt == 8);
			if (app_wdf_wren && app_wdf_end && app_wdf_rdy) begin
				wdf_data <= app_wdf_data;
				wdf_mask <= app_wdf_mask;
			end
			if (app_en && app_rdy) begin
				if (app_cmd == 3'b000) begin
					write_strip(app_addr, wdf_data, wdf_mask);
					wr_log[4'(wr_cmds)] <= app_addr;
					wr_cmds <= wr_cmds + 1;
				end else begin
					rd_adr_q.push_back(app_addr);
					// Read latency of 1 to 8 cycles
					rd_due_q.push_back(cycle + 1 + int'(rnd[6:4]));
					rd_cmds <= rd_cmds + 1;
				end
			end
			// Strips leave in command order
			app_rd_data_valid <= 1'b0;
			if (rd_due_q.size() > 0 && rd_due_q[0] <= cycle) begin
				app_rd_data <= read_strip(rd_adr_q.pop_front());
				void'(rd_due_q.pop_front());
				app_rd_data_valid <= 1'b1;
			end
		end
	end

endmodule

//--- tests/tb_mpmc.sv
`timescale 1ns/1ps

module tb_mpmc;

	localparam int ADDR_WIDTH = 29;
	localparam int CYCLES_PER_TEST = 400;
	// CPU half of a paired write sits this far above the display address
	localparam logic [31:0] PAIR_OFFSET = 32'h200;

	logic mem_ui_clk;
	logic mem_ui_rst;
	logic disp_cyc;
	logic disp_stb;
	logic disp_we;
	logic [15:0] disp_sel;
	logic [31:0] disp_adr;
	logic [127:0] disp_dat_i;
	logic [127:0] disp_dat_o;
	logic disp_ack;
	logic nar_cyc;
	logic nar_stb;
	logic nar_we;
	logic [3:0] nar_sel;
	logic [31:0] nar_adr;
	logic [31:0] nar_dat_i;
	logic [31:0] nar_dat_o;
	logic nar_ack;
	logic cpu_cyc;
	logic cpu_stb;
	logic cpu_we;
	logic [7:0] cpu_sel;
	logic [31:0] cpu_adr;
	logic [63:0] cpu_dat_i;
	logic [63:0] cpu_dat_o;
	logic cpu_ack;
	logic init_calib_complete;
	logic [ADDR_WIDTH-1:0] app_addr;
	logic [2:0] app_cmd;
	logic app_en;
	logic [127:0] app_wdf_data;
	logic [15:0] app_wdf_mask;
	logic app_wdf_wren;
	logic app_wdf_end;
	logic app_rdy;
	logic app_wdf_rdy;
	logic [127:0] app_rd_data;
	logic app_rd_data_valid;
	int rd_cmds;
	int wr_cmds;

	// Trace rows
	logic [8*16-1:0] tr_name [$];
	logic [3:0] tr_port [$];
	logic [3:0] tr_op [$];
	logic [31:0] tr_adr [$];
	logic [15:0] tr_sel [$];
	logic [127:0] tr_data [$];
	logic [127:0] tr_exp [$];

	int errors = 0;
	int passes = 0;
	int fails = 0;
	int cycles = 0;
	int cycle_limit = 0;

	mpmc_top #(.ADDR_WIDTH(ADDR_WIDTH)) UUT (.*);

	mem_model #(.ADDR_WIDTH(ADDR_WIDTH)) u_mem (.*);

	always #10 mem_ui_clk = ~mem_ui_clk;

	always @(posedge mem_ui_clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Timeout after %0d cycles, a client request was never acknowledged", cycles);
			$display("Test FAILED");
			$finish;
		end
	end

	// ----------------------------------------------------------
	// Client port access
	// ----------------------------------------------------------
	task automatic drive_port(input logic [3:0] port, input logic on, input logic we,
			input logic [31:0] adr, input logic [15:0] sel, input logic [127:0] data);
		case (port)
		4'd0: begin
			disp_cyc = on;
			disp_stb = on;
			disp_we = we;
			disp_adr = adr;
			disp_sel = sel;
			disp_dat_i = data;
		end
		4'd1: begin
			nar_cyc = on;
			nar_stb = on;
			nar_we = we;
			nar_adr = adr;
			nar_sel = sel[3:0];
			nar_dat_i = data[31:0];
		end
		4'd2: begin
			cpu_cyc = on;
			cpu_stb = on;
			cpu_we = we;
			cpu_adr = adr;
			cpu_sel = sel[7:0];
			cpu_dat_i = data[63:0];
		end
		default: ;
		endcase
	endtask

	function automatic logic port_ack(input logic [3:0] port);
		case (port)
		4'd0: return disp_ack;
		4'd1: return nar_ack;
		default: return cpu_ack;
		endcase
	endfunction

	function automatic logic [127:0] port_data(input logic [3:0] port);
		case (port)
		4'd0: return disp_dat_o;
		4'd1: return 128'(nar_dat_o);
		default: return 128'(cpu_dat_o);
		endcase
	endfunction

	// Strips in one cache line of each port
	function automatic int line_strips(input logic [3:0] port);
		case (port)
		4'd0: return 4;
		4'd1: return 1;
		default: return 2;
		endcase
	endfunction

	task automatic run_access(input logic [3:0] port, input logic we, input logic [31:0] adr,
			input logic [15:0] sel, input logic [127:0] data, output logic [127:0] got,
			output int waits);
		waits = 0;
		@(negedge mem_ui_clk);
		drive_port(port, 1'b1, we, adr, sel, data);
		do begin
			@(negedge mem_ui_clk);
			waits++;
		end while (!port_ack(port));
		got = port_data(port);
		drive_port(port, 1'b0, 1'b0, adr, sel, data);
	endtask

	// Display and CPU writes raised in the same cycle
	task automatic write_pair(input logic [31:0] adr, input logic [15:0] sel,
			input logic [127:0] data);
		logic disp_done;
		logic cpu_done;
		disp_done = 1'b0;
		cpu_done = 1'b0;
		@(negedge mem_ui_clk);
		drive_port(4'd0, 1'b1, 1'b1, adr, sel, data);
		drive_port(4'd2, 1'b1, 1'b1, adr + PAIR_OFFSET, sel, data);
		while (!(disp_done && cpu_done)) begin
			@(negedge mem_ui_clk);
			if (disp_ack) begin
				disp_done = 1'b1;
				drive_port(4'd0, 1'b0, 1'b0, adr, sel, data);
			end
			if (cpu_ack) begin
				cpu_done = 1'b1;
				drive_port(4'd2, 1'b0, 1'b0, adr + PAIR_OFFSET, sel, data);
			end
		end
	endtask

	// ----------------------------------------------------------
	// Trace handling
	// ----------------------------------------------------------
	task automatic load_trace();
		int fd;
		int n;
		logic [8*128-1:0] line;
		logic [8*16-1:0] name;
		logic [3:0] port;
		logic [3:0] op;
		logic [31:0] adr;
		logic [15:0] sel;
		logic [127:0] data;
		logic [127:0] exp;
		fd = $fopen("tests/mpmc_trace.txt", "r");
		if (fd == 0) begin
			$display("Cannot open tests/mpmc_trace.txt");
			return;
		end
		while ($fgets(line, fd) > 0) begin
			n = $sscanf(line, "%s %h %h %h %h %h %h", name, port, op, adr, sel, data, exp);
			if (n == 7) begin
				tr_name.push_back(name);
				tr_port.push_back(port);
				tr_op.push_back(op);
				tr_adr.push_back(adr);
				tr_sel.push_back(sel);
				tr_data.push_back(data);
				tr_exp.push_back(exp);
			end
		end
		$fclose(fd);
	endtask

	task automatic run_test(input int idx);
		logic [3:0] port;
		logic [3:0] op;
		logic [127:0] got;
		logic [ADDR_WIDTH-1:0] first_adr;
		int rd_before;
		int wr_before;
		int err_before;
		int rd_want;
		int wr_want;
		int waits;
		port = tr_port[idx];
		op = tr_op[idx];
		rd_before = rd_cmds;
		wr_before = wr_cmds;
		err_before = errors;
		if (port == 4'd3) begin
			write_pair(tr_adr[idx], tr_sel[idx], tr_data[idx]);
		end else begin
			run_access(port, op == 4'd0, tr_adr[idx], tr_sel[idx], tr_data[idx], got, waits);
			if (op != 4'd0 && got !== tr_exp[idx]) begin
				$display("Error %0s: expected %h, got %h", tr_name[idx], tr_exp[idx], got);
				errors++;
			end
			// A hit answers on the first edge
			if (op == 4'd1 && waits != 1) begin
				$display("Error %0s: hit ack cycles expected 1, got %0d", tr_name[idx], waits);
				errors++;
			end
		end
		// A hit costs no memory read, a miss fetches one whole line
		rd_want = (op == 4'd2) ? line_strips(port) : 0;
		if (rd_cmds - rd_before != rd_want) begin
			$display("Error %0s: read commands expected %0d, got %0d", tr_name[idx], rd_want,
				rd_cmds - rd_before);
			errors++;
		end
		wr_want = (port == 4'd3) ? 2 : ((op == 4'd0) ? 1 : 0);
		if (wr_cmds - wr_before != wr_want) begin
			$display("Error %0s: write commands expected %0d, got %0d", tr_name[idx], wr_want,
				wr_cmds - wr_before);
			errors++;
		end else if (port == 4'd3) begin
			// Display wins the tie
			first_adr = u_mem.wr_log[4'(wr_before)];
			if (first_adr !== ADDR_WIDTH'(tr_adr[idx] & 32'hffff_fff0)) begin
				$display("Error %0s: first write address expected %h, got %h", tr_name[idx],
					ADDR_WIDTH'(tr_adr[idx] & 32'hffff_fff0), first_adr);
				errors++;
			end
		end
		if (errors == err_before) begin
			passes++;
			$display("%0s: pass", tr_name[idx]);
		end else begin
			fails++;
			$display("%0s: fail", tr_name[idx]);
		end
	endtask

	initial begin
		mem_ui_clk = 1'b0;
		mem_ui_rst = 1'b1;
		drive_port(4'd0, 1'b0, 1'b0, '0, '0, '0);
		drive_port(4'd1, 1'b0, 1'b0, '0, '0, '0);
		drive_port(4'd2, 1'b0, 1'b0, '0, '0, '0);
		load_trace();
		cycle_limit = CYCLES_PER_TEST * (tr_name.size() + 1);
		repeat (5) @(posedge mem_ui_clk);
		@(negedge mem_ui_clk);
		mem_ui_rst = 1'b0;
		while (!init_calib_complete)
			@(negedge mem_ui_clk);
		for (int i = 0; i < tr_name.size(); i++)
			run_test(i);
		$display("Summary: %0d tests, %0d passed, %0d failed, %0d check errors",
			tr_name.size(), passes, fails, errors);
		if (fails == 0 && tr_name.size() > 0) begin
			$display("Test OK");
		end else begin
			if (tr_name.size() == 0)
				$display("No tests were read from the trace file");
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- src.f
rtl/mem_ui_pkg.sv
rtl/client_pkg.sv
rtl/request_select.sv
rtl/app_sequencer.sv
rtl/line_cache.sv
rtl/ack_ctrl.sv
rtl/mpmc_top.sv
tests/mem_model.sv
tests/tb_mpmc.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_mpmc -f src.f -o tb_mpmc || exit 1
out=$(./obj_dir/tb_mpmc)
echo "$out"
echo "$out" | grep -qx "Test OK" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

//--- tests/mpmc_trace.txt
# columns: name port op address sel data expected, all numbers in hex
# port: 0 display, 1 narrow, 2 CPU, 3 display and CPU write together; op: 0 write, 1 read hit, 2 read miss
nar_wr       1 0 00000100 000f deadbeef 0
nar_rd       1 2 00000100 000f 0 deadbeef
nar_rd_w1    1 1 00000104 000f 0 5a5a0104
nar_rd_w3    1 1 0000010c 000f 0 5a5a010c
disp_rd      0 2 00000200 ffff 0 5a5a020c5a5a02085a5a02045a5a0200
disp_rd_hit  0 1 00000230 ffff 0 5a5a023c5a5a02385a5a02345a5a0230
cpu_wr_part  2 0 00000300 003c 1122334455667788 0
cpu_rd_part  2 2 00000300 00ff 0 5a5a334455660300
cpu_rd_fill  2 2 00000400 00ff 0 5a5a04045a5a0400
cpu_rd_hit   2 1 00000418 00ff 0 5a5a041c5a5a0418
disp_wr_inv  0 0 00000410 ffff 44444444333333332222222211111111 0
cpu_rd_inv   2 2 00000418 00ff 0 4444444433333333
both_wr      3 0 00000500 ffff d3d3d3d3c2c2c2c2b1b1b1b1a0a0a0a0 0
disp_rd_b    0 2 00000500 ffff 0 d3d3d3d3c2c2c2c2b1b1b1b1a0a0a0a0
cpu_rd_b     2 2 00000700 00ff 0 b1b1b1b1a0a0a0a0
disp_rd_b2   0 1 00000530 ffff 0 5a5a053c5a5a05385a5a05345a5a0530
